/* Makefile */
# Verilator flow for the power-management subsystem testbench
TOP := pwr_mgmt_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f vlog.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG) || ! grep -q "sim passed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* dv/pwr_mgmt_assert.sv */
//********************
// Concurrent assertions on the halt FSM and the clock gate
// Bound into the subsystem top, where both blocks are reachable
//********************

`timescale 1ns/10ps
`default_nettype none

module pwr_mgmt_assert (
    input logic                       clk,
    input logic                       cptra_rst_b,
    input logic                       halt_req,
    input pwr_types_pkg::halt_state_e state,
    input logic                       cpu_halt_status,
    input logic                       disable_clk_lat,
    input logic                       disable_soc_ifc_clk_lat
);

    // Failed assertions so far
    int unsigned fail_count = 0;

    // The request is a strobe, never a level
    halt_req_one_cycle: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        halt_req |=> !halt_req)
        else begin
            $error("halt_req stayed high for a second cycle");
            fail_count++;
        end

    // The core must have drained before the halt is declared
    halted_only_from_drain: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (state == pwr_types_pkg::HALTED) && ($past(state) != pwr_types_pkg::HALTED)
        |-> ($past(state) == pwr_types_pkg::DRAIN))
        else begin
            $error("HALTED entered from a state other than DRAIN");
            fail_count++;
        end

    // Latches closed at this edge hold the gate decision for the coming high phase
    // With the CPU running neither may block its clock
    clocks_follow_when_running: assert property (@(posedge clk) disable iff (!cptra_rst_b)
        !cpu_halt_status |-> !disable_clk_lat && !disable_soc_ifc_clk_lat)
        else begin
            $error("A gated clock was blocked while the CPU was not halted");
            fail_count++;
        end

endmodule

bind pwr_mgmt_top pwr_mgmt_assert u_pwr_mgmt_assert (
    .clk                     (clk),
    .cptra_rst_b             (cptra_rst_b),
    .halt_req                (halt_req),
    .state                   (state),
    .cpu_halt_status         (cpu_halt_status),
    .disable_clk_lat         (u_clk_gate.disable_clk_lat),
    .disable_soc_ifc_clk_lat (u_clk_gate.disable_soc_ifc_clk_lat)
);

`default_nettype wire

/* dv/pwr_mgmt_checker.sv */
//********************
// Reference model of the power-management subsystem
// Predicts gated clocks, halt status and read data, and counts mismatches
//********************

`timescale 1ns/10ps
`default_nettype none

module pwr_mgmt_checker (
    input  logic                          clk,
    input  logic                          cptra_rst_b,
    input  pwr_types_pkg::apb_req_t       apb,
    input  logic                          cpu_idle,
    input  pwr_types_pkg::wake_irq_t      wake_irq,
    input  pwr_types_pkg::generic_wires_t generic_input_wires,
    input  pwr_types_pkg::apb_data_t      prdata,
    input  logic                          cpu_halt_status,
    input  logic                          clk_cg,
    input  logic                          soc_ifc_clk_cg,
    output int unsigned                   err_count
);

    pwr_types_pkg::halt_state_e    state_m;
    pwr_types_pkg::wake_irq_t      mask_m;
    pwr_types_pkg::generic_wires_t wires_m;
    logic                          gate_en_m;
    logic                          halt_req_m;
    logic                          wr_en;
    logic                          gated;
    logic                          exp_clk_cg;
    logic                          exp_soc_clk_cg;
    int unsigned                   errors = 0;

    assign err_count = errors;

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %0b actual %0b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string name, input pwr_types_pkg::apb_data_t exp,
                              input pwr_types_pkg::apb_data_t act);
        if (act !== exp) begin
            $display("** Error at %0t: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // Register view as software should see it, built from the model
    function automatic pwr_types_pkg::apb_data_t read_value(input pwr_types_pkg::apb_addr_t a);
        pwr_types_pkg::apb_data_t v;
        v = '0;
        if (a == pwr_regs_pkg::CTRL_ADDR) v[pwr_regs_pkg::CTRL_GATE_EN_BIT] = gate_en_m;
        if (a == pwr_regs_pkg::WAKE_MASK_ADDR) v[7:0] = mask_m;
        if (a == pwr_regs_pkg::STATUS_ADDR) begin
            v[0]   = (state_m == pwr_types_pkg::HALTED);
            v[2:1] = state_m;
        end
        return v;
    endfunction

    always @(posedge clk) begin
        if (!cptra_rst_b) begin
            state_m        = pwr_types_pkg::RUN;
            // Every wake line unmasked out of reset
            mask_m         = 8'hFF;
            wires_m        = '0;
            gate_en_m      = 1'b0;
            halt_req_m     = 1'b0;
            exp_clk_cg     = 1'b1;
            exp_soc_clk_cg = 1'b1;
        end else begin
            // Gate decision for the high phase that starts here, from pre-edge values
            gated          = gate_en_m && (state_m == pwr_types_pkg::HALTED)
                             && (generic_input_wires == wires_m);
            exp_clk_cg     = !gated;
            exp_soc_clk_cg = !(gated && !apb.psel);
            case (state_m)
                pwr_types_pkg::RUN: if (halt_req_m) state_m = pwr_types_pkg::DRAIN;
                pwr_types_pkg::DRAIN: begin
                    if (|(wake_irq & mask_m)) state_m = pwr_types_pkg::RUN;
                    else if (cpu_idle) state_m = pwr_types_pkg::HALTED;
                end
                pwr_types_pkg::HALTED: if (|(wake_irq & mask_m)) state_m = pwr_types_pkg::RUN;
                default: state_m = pwr_types_pkg::RUN;
            endcase
            // Register writes land on this edge and the halt strobe follows one cycle later
            wr_en      = apb.psel && apb.penable && apb.pwrite;
            halt_req_m = wr_en && (apb.paddr == pwr_regs_pkg::CTRL_ADDR)
                         && apb.pwdata[pwr_regs_pkg::CTRL_HALT_REQ_BIT];
            if (wr_en && apb.paddr == pwr_regs_pkg::CTRL_ADDR)
                gate_en_m = apb.pwdata[pwr_regs_pkg::CTRL_GATE_EN_BIT];
            if (wr_en && apb.paddr == pwr_regs_pkg::WAKE_MASK_ADDR) mask_m = apb.pwdata[7:0];
            wires_m = generic_input_wires;
        end
        // Mid high phase, where gated clocks and flop outputs have settled
        #1;
        check_bit("clk_cg", exp_clk_cg, clk_cg);
        check_bit("soc_ifc_clk_cg", exp_soc_clk_cg, soc_ifc_clk_cg);
        check_bit("cpu_halt_status", state_m == pwr_types_pkg::HALTED, cpu_halt_status);
        check_word("prdata", apb.psel ? read_value(apb.paddr) : '0, prdata);
    end

endmodule

`default_nettype wire

/* dv/pwr_mgmt_tb.sv */
//********************
// Testbench of the power-management subsystem
// Random register traffic, then a directed halt, access, wire change and wake run
//********************

`timescale 1ns/10ps
`default_nettype none

module pwr_mgmt_tb;

    logic                          clk;
    logic                          cptra_rst_b;
    pwr_types_pkg::apb_req_t       apb;
    logic                          cpu_idle;
    pwr_types_pkg::wake_irq_t      wake_irq;
    pwr_types_pkg::generic_wires_t generic_input_wires;
    pwr_types_pkg::apb_data_t      prdata;
    logic                          cpu_halt_status;
    logic                          clk_cg;
    logic                          soc_ifc_clk_cg;
    int unsigned                   mismatches;
    int                            timeouts;
    int                            seed;
    logic                          wake_noise;
    logic                          wire_noise;
    logic [31:0]                   rnd;

    pwr_mgmt_top uut (
        .clk (clk), .cptra_rst_b (cptra_rst_b), .apb (apb), .cpu_idle (cpu_idle),
        .wake_irq (wake_irq), .generic_input_wires (generic_input_wires), .prdata (prdata),
        .cpu_halt_status (cpu_halt_status), .clk_cg (clk_cg), .soc_ifc_clk_cg (soc_ifc_clk_cg)
    );

    pwr_mgmt_checker u_checker (
        .clk (clk), .cptra_rst_b (cptra_rst_b), .apb (apb), .cpu_idle (cpu_idle),
        .wake_irq (wake_irq), .generic_input_wires (generic_input_wires), .prdata (prdata),
        .cpu_halt_status (cpu_halt_status), .clk_cg (clk_cg),
        .soc_ifc_clk_cg (soc_ifc_clk_cg), .err_count (mismatches)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // One clock of background traffic on the idle, interrupt and wire inputs
    task automatic tick();
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        @(posedge clk);
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        if (r0[1:0] == 2'd0) cpu_idle <= !cpu_idle;
        // Wakes are rare single-cycle pulses on one line
        wake_irq <= (wake_noise && r0[6:2] == 5'd0) ? 8'h01 << r0[9:7] : 8'h00;
        // Roughly one wire change in eight cycles
        if (wire_noise && r0[12:10] == 3'd0) generic_input_wires <= generic_input_wires ^ {r1, r2};
    endtask

    // Setup cycle, access cycle, then the bus goes idle again
    task automatic bus_access(input logic wr, input pwr_types_pkg::apb_addr_t addr,
                              input pwr_types_pkg::apb_data_t data);
        pwr_types_pkg::apb_req_t req;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        tick();
        apb <= req;
        req.penable = 1'b1;
        tick();
        apb <= req;
        tick();
        apb <= '0;
    endtask

    task automatic pulse_wake(input pwr_types_pkg::wake_irq_t lines);
        tick();
        wake_irq <= lines;
    endtask

    // Halt latency depends on cpu_idle, so poll with a bound
    task automatic wait_halt(input logic level);
        int  n;
        logic done;
        n    = 0;
        done = 1'b0;
        while (!done && n < 200) begin
            tick();
            #2;
            done = (cpu_halt_status === level);
            n++;
        end
        if (!done) begin
            $display("Timeout: cpu_halt_status did not reach %0b within 200 cycles", level);
            timeouts++;
        end
    endtask

    initial begin
        int i;
        seed = 32'h6ab31c78;
        cptra_rst_b = 1'b0;
        apb = '0;
        cpu_idle = 1'b0;
        wake_irq = '0;
        generic_input_wires = '0;
        timeouts = 0;
        wake_noise = 1'b0;
        wire_noise = 1'b0;
        repeat (16) tick();
        cptra_rst_b <= 1'b1;
        // Reset values, including an unmapped address
        bus_access(1'b0, pwr_regs_pkg::STATUS_ADDR, '0);
        bus_access(1'b0, pwr_regs_pkg::WAKE_MASK_ADDR, '0);
        bus_access(1'b0, pwr_regs_pkg::CTRL_ADDR, '0);
        bus_access(1'b0, 8'h40, '0);
        wake_noise = 1'b1;
        wire_noise = 1'b1;
        for (i = 0; i < 80; i++) begin
            rnd = $random(seed);
            case (rnd[1:0])
                2'd0: bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, $random(seed));
                2'd1: bus_access(1'b1, pwr_regs_pkg::WAKE_MASK_ADDR, $random(seed));
                2'd2: bus_access(1'b1, rnd[9:2] | 8'h10, $random(seed));
                default: bus_access(1'b0, {4'h0, rnd[3:2], 2'b00}, '0);
            endcase
            repeat (rnd[11:10]) tick();
        end
        // Quiet inputs and a wake on every line bring the FSM back to RUN
        wake_noise = 1'b0;
        wire_noise = 1'b0;
        bus_access(1'b1, pwr_regs_pkg::WAKE_MASK_ADDR, 32'hFF);
        pulse_wake(8'hFF);
        wait_halt(1'b0);
        bus_access(1'b1, pwr_regs_pkg::WAKE_MASK_ADDR, 32'h0F);
        bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, 32'h1);
        bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, 32'h3);
        wait_halt(1'b1);
        repeat (8) tick();
        bus_access(1'b0, pwr_regs_pkg::STATUS_ADDR, '0);
        bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, 32'h3);
        wire_noise = 1'b1;
        repeat (40) tick();
        wire_noise = 1'b0;
        pulse_wake(8'h80);
        repeat (4) tick();
        bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, 32'h0);
        repeat (6) tick();
        bus_access(1'b1, pwr_regs_pkg::CTRL_ADDR, 32'h1);
        repeat (4) tick();
        pulse_wake(8'h04);
        wait_halt(1'b0);
        repeat (4) tick();
        $display("Checks done: %0d mismatches, %0d assertion failures, %0d timeouts",
                 mismatches, uut.u_pwr_mgmt_assert.fail_count, timeouts);
        if (mismatches == 0 && uut.u_pwr_mgmt_assert.fail_count == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Bound on the whole run
    initial begin
        repeat (20000) @(posedge clk);
        $display("Run exceeded its cycle limit before the sequence finished");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/clk_gate.sv */
//********************
// Glitch-free gating of the core clock and the SoC-interface clock
// Both are stopped while the CPU is halted and gating is enabled
//********************

`timescale 1ns/10ps
`default_nettype none

module clk_gate (
    input  logic                          clk,
    input  logic                          cptra_rst_b,
    input  logic                          psel,
    input  logic                          clk_gate_en,
    input  logic                          cpu_halt_status,
    input  pwr_types_pkg::generic_wires_t generic_input_wires,
    output logic                          clk_cg,
    output logic                          soc_ifc_clk_cg
);

    pwr_types_pkg::generic_wires_t generic_input_wires_f;
    logic                          wires_changed;
    logic                          disable_clk;
    logic                          disable_soc_ifc_clk;
    logic                          disable_clk_lat;
    logic                          disable_soc_ifc_clk_lat;

    // Copy of the wires from the previous cycle, for change detection
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            generic_input_wires_f <= '0;
        end else begin
            generic_input_wires_f <= generic_input_wires;
        end
    end

    // Disable conditions
    // Any wire change wakes both clocks for a cycle, a bus select keeps the SoC clock alive
    always_comb begin
        wires_changed       = (generic_input_wires != generic_input_wires_f);
        disable_clk         = clk_gate_en && cpu_halt_status && !wires_changed;
        disable_soc_ifc_clk = disable_clk && !psel;
    end

    // Disables are captured while clk is low
    // They stay frozen through the high phase so the gated clocks never glitch
    always_latch begin
        if (!cptra_rst_b) begin
            disable_clk_lat         = 1'b0;
            disable_soc_ifc_clk_lat = 1'b0;
        end else if (!clk) begin
            disable_clk_lat         = disable_clk;
            disable_soc_ifc_clk_lat = disable_soc_ifc_clk;
        end
    end

    // Gated clocks
    always_comb begin
        clk_cg         = clk && !disable_clk_lat;
        soc_ifc_clk_cg = clk && !disable_soc_ifc_clk_lat;
    end

endmodule

`default_nettype wire

/* hdl/halt_ctrl.sv */
//********************
// Halt FSM that moves the CPU from run to halted once the core is idle
// A wake interrupt on an unmasked line takes it back to run
//********************

`timescale 1ns/10ps
`default_nettype none

module halt_ctrl (
    input  logic                       clk,
    input  logic                       cptra_rst_b,
    input  logic                       halt_req,
    input  logic                       cpu_idle,
    input  pwr_types_pkg::wake_irq_t   wake_irq,
    input  pwr_types_pkg::wake_irq_t   wake_mask,
    output pwr_types_pkg::halt_state_e state,
    output logic                       cpu_halt_status
);

    pwr_types_pkg::halt_state_e state_next;
    logic                       wake;

    // A mask bit at 1 lets its interrupt line wake the CPU
    always_comb begin
        wake = |(wake_irq & wake_mask);
    end

    // Next-state logic
    always_comb begin
        state_next = state;
        case (state)
            pwr_types_pkg::RUN: begin
                // Only a request seen in RUN starts a halt
                if (halt_req) begin
                    state_next = pwr_types_pkg::DRAIN;
                end
            end
            pwr_types_pkg::DRAIN: begin
                // A wake aborts the drain, even if the core just went idle
                if (wake) begin
                    state_next = pwr_types_pkg::RUN;
                end else if (cpu_idle) begin
                    state_next = pwr_types_pkg::HALTED;
                end
            end
            pwr_types_pkg::HALTED: begin
                // Further halt requests are ignored here
                if (wake) begin
                    state_next = pwr_types_pkg::RUN;
                end
            end
            default: begin
                // Unused encoding, recover to RUN
                state_next = pwr_types_pkg::RUN;
            end
        endcase
    end

    // State register
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state <= pwr_types_pkg::RUN;
        end else begin
            state <= state_next;
        end
    end

    // Halt status flop
    // Loaded from the next state so that it rises on the same edge that enters HALTED
    // and falls on the same edge that leaves it
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            cpu_halt_status <= 1'b0;
        end else begin
            cpu_halt_status <= (state_next == pwr_types_pkg::HALTED);
        end
    end

endmodule

`default_nettype wire

/* hdl/pwr_csr.sv */
//********************
// APB-style register block of the power-management subsystem
// Holds the gating enable and wake mask, pulses the halt request, reports status
//********************

`timescale 1ns/10ps
`default_nettype none

module pwr_csr (
    input  logic                      clk,
    input  logic                      cptra_rst_b,
    input  pwr_types_pkg::apb_req_t   apb,
    input  pwr_types_pkg::halt_state_e state,
    input  logic                      cpu_halt_status,
    output pwr_types_pkg::pwr_cfg_t   cfg,
    output logic                      halt_req,
    output pwr_types_pkg::apb_data_t  prdata
);

    logic                      wr_en;
    logic                      ctrl_wr;
    logic                      mask_wr;
    logic                      halt_req_set;
    logic                      gate_en_q;
    pwr_types_pkg::wake_irq_t  wake_mask_q;

    // A write completes in the access phase, with setup already seen
    always_comb begin
        wr_en   = apb.psel && apb.penable && apb.pwrite;
        ctrl_wr = wr_en && (apb.paddr == pwr_regs_pkg::CTRL_ADDR);
        mask_wr = wr_en && (apb.paddr == pwr_regs_pkg::WAKE_MASK_ADDR);
        // Only a CTRL write with the request bit set asks for a halt
        halt_req_set = ctrl_wr && apb.pwdata[pwr_regs_pkg::CTRL_HALT_REQ_BIT];
    end

    // Configuration registers
    // Writes to unmapped addresses fall through without touching anything
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            gate_en_q   <= pwr_regs_pkg::CTRL_RESET[pwr_regs_pkg::CTRL_GATE_EN_BIT];
            wake_mask_q <= pwr_regs_pkg::WAKE_MASK_RESET;
        end else begin
            if (ctrl_wr) begin
                gate_en_q <= apb.pwdata[pwr_regs_pkg::CTRL_GATE_EN_BIT];
            end
            if (mask_wr) begin
                wake_mask_q <= apb.pwdata[7:0];
            end
        end
    end

    // Halt request pulse
    // It is high for the single cycle after the CTRL write edge and clears by itself
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            halt_req <= 1'b0;
        end else begin
            halt_req <= halt_req_set;
        end
    end

    // Configuration bundle to the halt FSM and the clock gate
    always_comb begin
        cfg.clk_gate_en = gate_en_q;
        cfg.wake_mask   = wake_mask_q;
    end

    // Read mux, driven straight from the address while psel is high
    // The halt request bit of CTRL is never stored, so it reads back 0
    always_comb begin
        prdata = '0;
        if (apb.psel) begin
            case (apb.paddr)
                pwr_regs_pkg::CTRL_ADDR: begin
                    prdata[pwr_regs_pkg::CTRL_GATE_EN_BIT] = gate_en_q;
                end
                pwr_regs_pkg::WAKE_MASK_ADDR: begin
                    prdata[7:0] = wake_mask_q;
                end
                pwr_regs_pkg::STATUS_ADDR: begin
                    // Live view of the FSM, no copy kept here
                    prdata[0]   = cpu_halt_status;
                    prdata[2:1] = state;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/pwr_mgmt_top.sv */
//********************
// Top of the power-management subsystem
// Ties the register block, the halt FSM and the clock gate together
//********************

`timescale 1ns/10ps
`default_nettype none

module pwr_mgmt_top (
    input  logic                          clk,
    input  logic                          cptra_rst_b,
    input  pwr_types_pkg::apb_req_t       apb,
    input  logic                          cpu_idle,
    input  pwr_types_pkg::wake_irq_t      wake_irq,
    input  pwr_types_pkg::generic_wires_t generic_input_wires,
    output pwr_types_pkg::apb_data_t      prdata,
    output logic                          cpu_halt_status,
    output logic                          clk_cg,
    output logic                          soc_ifc_clk_cg
);

    pwr_types_pkg::pwr_cfg_t    cfg;
    pwr_types_pkg::halt_state_e state;
    logic                       halt_req;

    // Software view, configuration and status
    pwr_csr u_pwr_csr (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .apb             (apb),
        .state           (state),
        .cpu_halt_status (cpu_halt_status),
        .cfg             (cfg),
        .halt_req        (halt_req),
        .prdata          (prdata)
    );

    // Halt sequencing
    halt_ctrl u_halt_ctrl (
        .clk             (clk),
        .cptra_rst_b     (cptra_rst_b),
        .halt_req        (halt_req),
        .cpu_idle        (cpu_idle),
        .wake_irq        (wake_irq),
        .wake_mask       (cfg.wake_mask),
        .state           (state),
        .cpu_halt_status (cpu_halt_status)
    );

    // The bus select keeps the SoC-interface clock running during an access
    clk_gate u_clk_gate (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .psel                (apb.psel),
        .clk_gate_en         (cfg.clk_gate_en),
        .cpu_halt_status     (cpu_halt_status),
        .generic_input_wires (generic_input_wires),
        .clk_cg              (clk_cg),
        .soc_ifc_clk_cg      (soc_ifc_clk_cg)
    );

endmodule

`default_nettype wire

/* hdl/pwr_regs_pkg.sv */
//********************
// Register map of the power-management register block
// Addresses, field positions and reset values
//********************

`default_nettype none

package pwr_regs_pkg;

    // Control register
    // Bit 0 is the gating enable, bit 1 a self-clearing halt request that reads 0
    localparam pwr_types_pkg::apb_addr_t CTRL_ADDR = 8'h00;

    // Wake interrupt mask, one bit per line in bits 7:0
    localparam pwr_types_pkg::apb_addr_t WAKE_MASK_ADDR = 8'h04;

    // Read-only status, bit 0 halted and bits 2:1 the halt FSM state
    localparam pwr_types_pkg::apb_addr_t STATUS_ADDR = 8'h08;

    // Field positions inside CTRL
    localparam int CTRL_GATE_EN_BIT  = 0;
    localparam int CTRL_HALT_REQ_BIT = 1;

    // Reset values, gating off and every wake line unmasked
    localparam pwr_types_pkg::apb_data_t CTRL_RESET      = 32'h0000_0000;
    localparam pwr_types_pkg::wake_irq_t WAKE_MASK_RESET = 8'hFF;

endpackage

`default_nettype wire

/* hdl/pwr_types_pkg.sv */
//********************
// Shared types of the power-management subsystem
// Bus request, configuration bundle and halt FSM states, used by RTL and testbench
//********************

`default_nettype none

package pwr_types_pkg;

    // Register byte address on the APB-style bus
    typedef logic [7:0] apb_addr_t;

    // Bus data word for both write and read data
    typedef logic [31:0] apb_data_t;

    // Generic input wires coming in from the SoC
    typedef logic [63:0] generic_wires_t;

    // One bit per wake interrupt line
    typedef logic [7:0] wake_irq_t;

    // Halt controller states
    typedef enum logic [1:0] {
        RUN    = 2'd0,
        DRAIN  = 2'd1,
        HALTED = 2'd2
    } halt_state_e;

    // APB-style request bundle, 43 bits
    // No pready here because every access completes in one cycle
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // Configuration from the register block to the halt FSM and the clock gate
    typedef struct packed {
        logic      clk_gate_en;
        wake_irq_t wake_mask;
    } pwr_cfg_t;

endpackage

`default_nettype wire

/* vlog.f */
hdl/pwr_types_pkg.sv
hdl/pwr_regs_pkg.sv
hdl/pwr_csr.sv
hdl/halt_ctrl.sv
hdl/clk_gate.sv
hdl/pwr_mgmt_top.sv
dv/pwr_mgmt_assert.sv
dv/pwr_mgmt_checker.sv
dv/pwr_mgmt_tb.sv
